/* panel_cfg_pkg.sv */
// default geometry and timing of the HUB75 panel, plus the colour channel order
// the top level, the submodule parameter defaults and the testbench import this
package panel_cfg_pkg;

    // columns per row
    localparam int DEFAULT_PIXEL_WIDTH = 16;
    // total rows, top and bottom half together, so 4 row pairs
    localparam int DEFAULT_PANEL_ROWS = 8;
    // bits per colour channel, one bit plane each
    localparam int DEFAULT_BRIGHTNESS_LEVELS = 4;
    // lit cycles of the least significant plane
    localparam int DEFAULT_BRIGHTNESS_BASE_TIMEOUT = 4;
    // next plane may start shifting once this many lit cycles or fewer remain
    localparam int DEFAULT_BRIGHTNESS_OVERLAP = 8;

    // bit position of each channel inside an rgb triple
    typedef enum logic [1:0] {
        RED   = 2'd0,
        GREEN = 2'd1,
        BLUE  = 2'd2
    } color_e;

endpackage

/* scan_pkg.sv */
// scan sequencing definitions shared by the scan controller and the lit time generator
// matrix_scan and brightness_timeout import this
package scan_pkg;

    // widest mask first_mask can describe
    localparam int MAX_BRIGHTNESS_LEVELS = 32;

    // one pass over a bit plane of a row pair
    typedef enum logic [2:0] {
        IDLE,
        // column address out, frame buffer fetch
        SHIFT_ADDR,
        // pixel clock with the fetched bits on the rgb lines
        SHIFT_CLK,
        // wait for the leds to go dark, then latch
        LATCH,
        // lit time of the latched plane, may overlap the next shift
        HOLD
    } scan_state_e;

    // one-hot mask of the most significant bit plane
    // callers cut the result down to their own level count
    function automatic logic [MAX_BRIGHTNESS_LEVELS-1:0] first_mask(input int levels);
        logic [MAX_BRIGHTNESS_LEVELS-1:0] mask;
        mask = '0;
        mask[levels-1] = 1'b1;
        return mask;
    endfunction

endpackage

/* scan_if.sv */
// fetch request path from the scan controller to the frame buffer
// one strobe per column, with the row pair and the bit plane to read
interface scan_if import panel_cfg_pkg::*; #(
    parameter int PIXEL_WIDTH       = DEFAULT_PIXEL_WIDTH,
    parameter int PANEL_ROWS        = DEFAULT_PANEL_ROWS,
    parameter int BRIGHTNESS_LEVELS = DEFAULT_BRIGHTNESS_LEVELS
);

    // one cycle strobe, buffer registers the bits on the next edge
    logic                               fetch;
    // column being shifted, counts down to 0
    logic [$clog2(PIXEL_WIDTH)-1:0]     column_address;
    // row pair, the bottom half is this plus PANEL_ROWS/2
    logic [$clog2(PANEL_ROWS / 2)-1:0] row_address;
    // one-hot bit plane select
    logic [BRIGHTNESS_LEVELS-1:0]       brightness_mask;

    modport scan (
        output fetch,
        output column_address,
        output row_address,
        output brightness_mask
    );

    modport buffer (
        input fetch,
        input column_address,
        input row_address,
        input brightness_mask
    );

endinterface

/* scan_timer.sv */
// loadable down-counter with a running flag
// start loads a value, each step takes one off until the count sits at zero
module scan_timer #(
    parameter int COUNTER_WIDTH = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     step,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // most recent load value
    logic [COUNTER_WIDTH-1:0] last_value;

    // start wins over step
    // no wrap below zero
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter    <= '0;
            last_value <= '0;
        end else if (start) begin
            counter    <= value;
            last_value <= value;
        end else if (step && running) begin
            counter <= counter - 1'b1;
        end
    end

    // busy while anything is left
    assign running = (counter != '0);

    // the count only ever moves down from what was loaded
    counter_within_load: assert property (
        @(posedge clk_in) disable iff (reset)
        counter <= last_value
    ) else $error("scan_timer count above its last load value");

endmodule

/* brightness_timeout.sv */
// output enable generator for binary coded modulation
// row_latch starts a lit time that doubles with each more significant bit plane
module brightness_timeout import panel_cfg_pkg::*, scan_pkg::*; #(
    parameter int BRIGHTNESS_LEVELS       = DEFAULT_BRIGHTNESS_LEVELS,
    parameter int BRIGHTNESS_BASE_TIMEOUT = DEFAULT_BRIGHTNESS_BASE_TIMEOUT,
    parameter int BRIGHTNESS_OVERLAP      = DEFAULT_BRIGHTNESS_OVERLAP
) (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         row_latch,
    input  logic [BRIGHTNESS_LEVELS-1:0] brightness_mask_active,
    output logic                         output_enable,
    output logic                         exceeded_overlap
);

    // lit time of the msb plane, the longest one
    localparam int MAX_LIT = BRIGHTNESS_BASE_TIMEOUT << (BRIGHTNESS_LEVELS - 1);
    localparam int LIT_WIDTH = $clog2(MAX_LIT + 1);
    localparam logic [BRIGHTNESS_LEVELS-1:0] MSB_MASK =
        BRIGHTNESS_LEVELS'(first_mask(BRIGHTNESS_LEVELS));

    logic [LIT_WIDTH-1:0] lit_cycles;
    logic [LIT_WIDTH-1:0] lit_remaining;
    logic                 lit_running;

    // one-hot mask to lit duration
    // walk down from the msb, the time halves with every step
    always_comb begin
        lit_cycles = '0;
        for (int i = 0; i < BRIGHTNESS_LEVELS; i++) begin
            if (brightness_mask_active == (MSB_MASK >> i)) begin
                lit_cycles = LIT_WIDTH'(MAX_LIT >> i);
            end
        end
    end

    // loaded on the latch edge, so the leds light from the next cycle
    // counts one lit cycle per clock
    scan_timer #(
        .COUNTER_WIDTH(LIT_WIDTH)
    ) lit_timer_i (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (row_latch),
        .step   (1'b1),
        .value  (lit_cycles),
        .counter(lit_remaining),
        .running(lit_running)
    );

    assign output_enable = lit_running;

    // remaining count includes the current cycle
    // lets the scan controller start the next shift early
    assign exceeded_overlap = lit_running && (int'(lit_remaining) <= BRIGHTNESS_OVERLAP);

    // the scan controller must hand over exactly one plane per latch
    mask_onehot_at_latch: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |-> $onehot(brightness_mask_active)
    ) else $error("brightness mask not one-hot at row_latch");

endmodule

/* matrix_scan.sv */
// HUB75 scan controller that shifts one bit plane of one row pair per pass
// shifts columns, latches, then overlaps the next shift with the lit time
module matrix_scan import panel_cfg_pkg::*, scan_pkg::*; #(
    parameter int PIXEL_WIDTH             = DEFAULT_PIXEL_WIDTH,
    parameter int PANEL_ROWS              = DEFAULT_PANEL_ROWS,
    parameter int BRIGHTNESS_LEVELS       = DEFAULT_BRIGHTNESS_LEVELS,
    parameter int BRIGHTNESS_BASE_TIMEOUT = DEFAULT_BRIGHTNESS_BASE_TIMEOUT,
    parameter int BRIGHTNESS_OVERLAP      = DEFAULT_BRIGHTNESS_OVERLAP
) (
    input  logic                              clk_in,
    input  logic                              reset,
    scan_if.scan                              scan,
    output logic                              row_latch,
    output logic                              clk_pixel,
    output logic                              output_enable,
    output logic [$clog2(PANEL_ROWS / 2)-1:0] row_address_active
);

    localparam int COL_WIDTH = $clog2(PIXEL_WIDTH);
    localparam int ROW_PAIRS = PANEL_ROWS / 2;
    localparam int ROW_WIDTH = $clog2(ROW_PAIRS);
    localparam logic [BRIGHTNESS_LEVELS-1:0] MSB_MASK =
        BRIGHTNESS_LEVELS'(first_mask(BRIGHTNESS_LEVELS));

    scan_state_e state;
    scan_state_e state_next;

    // row pair and plane in the shift register right now
    // the lit copies move over on row_latch
    logic [ROW_WIDTH-1:0]         row_address;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_mask;

    logic [COL_WIDTH-1:0] column;
    logic                 column_running;
    logic                 column_start;
    logic                 exceeded_overlap;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       state_next = SHIFT_ADDR;
            SHIFT_ADDR: state_next = SHIFT_CLK;
            // column 0 was the last one
            SHIFT_CLK:  state_next = column_running ? SHIFT_ADDR : LATCH;
            // hold the latch until the previous plane has gone dark
            LATCH:      state_next = output_enable ? LATCH : HOLD;
            HOLD: begin
                if (!output_enable || exceeded_overlap) begin
                    state_next = SHIFT_ADDR;
                end
            end
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // every pass starts again at the last column
    assign column_start = (state_next == SHIFT_ADDR) && (state == IDLE || state == HOLD);

    // one column step per pixel clock so each column takes two cycles
    scan_timer #(
        .COUNTER_WIDTH(COL_WIDTH)
    ) column_timer_i (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (column_start),
        .step   (state == SHIFT_CLK),
        .value  (COL_WIDTH'(PIXEL_WIDTH - 1)),
        .counter(column),
        .running(column_running)
    );

    // fetch one cycle ahead of the pixel clock
    assign scan.fetch           = (state == SHIFT_ADDR);
    assign scan.column_address  = column;
    assign scan.row_address     = row_address;
    assign scan.brightness_mask = brightness_mask;

    assign clk_pixel = (state == SHIFT_CLK);
    // high only in the first dark cycle of LATCH since the next state is HOLD
    assign row_latch = (state == LATCH) && !output_enable;

    // planes run msb to lsb, then the row pair advances and wraps
    always_ff @(posedge clk_in) begin
        if (reset) begin
            row_address        <= '0;
            row_address_active <= '0;
            brightness_mask    <= MSB_MASK;
        end else if (row_latch) begin
            row_address_active <= row_address;
            if (brightness_mask[0]) begin
                brightness_mask <= MSB_MASK;
                if (row_address == ROW_WIDTH'(ROW_PAIRS - 1)) begin
                    row_address <= '0;
                end else begin
                    row_address <= row_address + 1'b1;
                end
            end else begin
                brightness_mask <= brightness_mask >> 1;
            end
        end
    end

    // the plane being latched sets the lit time
    brightness_timeout #(
        .BRIGHTNESS_LEVELS      (BRIGHTNESS_LEVELS),
        .BRIGHTNESS_BASE_TIMEOUT(BRIGHTNESS_BASE_TIMEOUT),
        .BRIGHTNESS_OVERLAP     (BRIGHTNESS_OVERLAP)
    ) brightness_i (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask),
        .output_enable         (output_enable),
        .exceeded_overlap      (exceeded_overlap)
    );

    // latch only while dark, and the lit time follows on the very next cycle
    latch_while_dark: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |-> !output_enable ##1 output_enable
    ) else $error("row_latch overlapped output_enable");

    // pixel clocks only while dark or inside the overlap window of the lit plane
    // and never together with the latch
    pixel_clock_clear_of_latch: assert property (
        @(posedge clk_in) disable iff (reset)
        clk_pixel |-> !row_latch && (!output_enable || exceeded_overlap)
    ) else $error("clk_pixel outside the overlap window or with row_latch");

endmodule

/* frame_buffer.sv */
// pixel memory of the whole panel, one rgb value per pixel
// written by a plain strobe, read one bit plane of a row pair per fetch
module frame_buffer import panel_cfg_pkg::*; #(
    parameter int PIXEL_WIDTH       = DEFAULT_PIXEL_WIDTH,
    parameter int PANEL_ROWS        = DEFAULT_PANEL_ROWS,
    parameter int BRIGHTNESS_LEVELS = DEFAULT_BRIGHTNESS_LEVELS
) (
    input  logic                           clk_in,
    input  logic                           reset,
    input  logic                           wr_en,
    input  logic [$clog2(PANEL_ROWS)-1:0]  wr_row,
    input  logic [$clog2(PIXEL_WIDTH)-1:0] wr_col,
    input  logic [BRIGHTNESS_LEVELS-1:0]   wr_red,
    input  logic [BRIGHTNESS_LEVELS-1:0]   wr_green,
    input  logic [BRIGHTNESS_LEVELS-1:0]   wr_blue,
    scan_if.buffer                         scan,
    output logic [2:0]                     rgb_top,
    output logic [2:0]                     rgb_bottom
);

    localparam int ROW_WIDTH = $clog2(PANEL_ROWS);
    localparam int ROW_PAIRS = PANEL_ROWS / 2;

    // three channels, indexed by color_e
    typedef logic [2:0][BRIGHTNESS_LEVELS-1:0] pixel_t;

    pixel_t pixel_mem [PANEL_ROWS][PIXEL_WIDTH];

    pixel_t               wr_pixel;
    logic [ROW_WIDTH-1:0] top_row;
    logic [ROW_WIDTH-1:0] bottom_row;
    pixel_t               top_pixel;
    pixel_t               bottom_pixel;

    // masked bit of one channel
    function automatic logic plane_bit(input pixel_t pixel, input color_e channel,
                                       input logic [BRIGHTNESS_LEVELS-1:0] mask);
        return |(pixel[channel] & mask);
    endfunction

    always_comb begin
        wr_pixel        = '0;
        wr_pixel[RED]   = wr_red;
        wr_pixel[GREEN] = wr_green;
        wr_pixel[BLUE]  = wr_blue;
    end

    // write takes effect on the edge, a read in the same cycle sees the old value
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            pixel_mem[wr_row][wr_col] <= wr_pixel;
        end
    end

    // bottom half row sits half a panel further down
    assign top_row      = ROW_WIDTH'(scan.row_address);
    assign bottom_row   = ROW_WIDTH'(scan.row_address) + ROW_WIDTH'(ROW_PAIRS);
    assign top_pixel    = pixel_mem[top_row][scan.column_address];
    assign bottom_pixel = pixel_mem[bottom_row][scan.column_address];

    // bits appear in the cycle after the fetch, together with clk_pixel
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else if (scan.fetch) begin
            rgb_top[RED]      <= plane_bit(top_pixel, RED, scan.brightness_mask);
            rgb_top[GREEN]    <= plane_bit(top_pixel, GREEN, scan.brightness_mask);
            rgb_top[BLUE]     <= plane_bit(top_pixel, BLUE, scan.brightness_mask);
            rgb_bottom[RED]   <= plane_bit(bottom_pixel, RED, scan.brightness_mask);
            rgb_bottom[GREEN] <= plane_bit(bottom_pixel, GREEN, scan.brightness_mask);
            rgb_bottom[BLUE]  <= plane_bit(bottom_pixel, BLUE, scan.brightness_mask);
        end
    end

endmodule

/* led_matrix_top.sv */
// top level of the HUB75 matrix driver
// frame buffer write port in, panel row, rgb and strobe lines out
module led_matrix_top import panel_cfg_pkg::*; #(
    parameter int PIXEL_WIDTH             = DEFAULT_PIXEL_WIDTH,
    parameter int PANEL_ROWS              = DEFAULT_PANEL_ROWS,
    parameter int BRIGHTNESS_LEVELS       = DEFAULT_BRIGHTNESS_LEVELS,
    parameter int BRIGHTNESS_BASE_TIMEOUT = DEFAULT_BRIGHTNESS_BASE_TIMEOUT,
    parameter int BRIGHTNESS_OVERLAP      = DEFAULT_BRIGHTNESS_OVERLAP
) (
    input  logic                              clk_in,
    input  logic                              reset,
    input  logic                              wr_en,
    input  logic [$clog2(PANEL_ROWS)-1:0]     wr_row,
    input  logic [$clog2(PIXEL_WIDTH)-1:0]    wr_col,
    input  logic [BRIGHTNESS_LEVELS-1:0]      wr_red,
    input  logic [BRIGHTNESS_LEVELS-1:0]      wr_green,
    input  logic [BRIGHTNESS_LEVELS-1:0]      wr_blue,
    output logic [2:0]                        rgb_top,
    output logic [2:0]                        rgb_bottom,
    output logic [$clog2(PANEL_ROWS / 2)-1:0] row_address,
    output logic                              clk_pixel,
    output logic                              row_latch,
    output logic                              output_enable
);

    // fetch requests, scan controller to frame buffer
    scan_if #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .PANEL_ROWS       (PANEL_ROWS),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) scan_bus ();

    // the panel shows the lit row pair, not the one being shifted
    matrix_scan #(
        .PIXEL_WIDTH            (PIXEL_WIDTH),
        .PANEL_ROWS             (PANEL_ROWS),
        .BRIGHTNESS_LEVELS      (BRIGHTNESS_LEVELS),
        .BRIGHTNESS_BASE_TIMEOUT(BRIGHTNESS_BASE_TIMEOUT),
        .BRIGHTNESS_OVERLAP     (BRIGHTNESS_OVERLAP)
    ) scan_i (
        .clk_in            (clk_in),
        .reset             (reset),
        .scan              (scan_bus.scan),
        .row_latch         (row_latch),
        .clk_pixel         (clk_pixel),
        .output_enable     (output_enable),
        .row_address_active(row_address)
    );

    frame_buffer #(
        .PIXEL_WIDTH      (PIXEL_WIDTH),
        .PANEL_ROWS       (PANEL_ROWS),
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) buffer_i (
        .clk_in    (clk_in),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_col    (wr_col),
        .wr_red    (wr_red),
        .wr_green  (wr_green),
        .wr_blue   (wr_blue),
        .scan      (scan_bus.buffer),
        .rgb_top   (rgb_top),
        .rgb_bottom(rgb_bottom)
    );

endmodule

/* tb_led_matrix.sv */
// directed testbench for the HUB75 matrix driver
// loads a random image, then follows the panel side of the scan against a reference model
module tb_led_matrix import panel_cfg_pkg::*; ();

    localparam int PIXEL_WIDTH      = DEFAULT_PIXEL_WIDTH;
    localparam int PANEL_ROWS       = DEFAULT_PANEL_ROWS;
    localparam int LEVELS           = DEFAULT_BRIGHTNESS_LEVELS;
    localparam int BASE_TIMEOUT     = DEFAULT_BRIGHTNESS_BASE_TIMEOUT;
    localparam int OVERLAP          = DEFAULT_BRIGHTNESS_OVERLAP;
    localparam int ROW_PAIRS        = PANEL_ROWS / 2;
    localparam int ROW_BITS         = $clog2(PANEL_ROWS);
    localparam int COL_BITS         = $clog2(PIXEL_WIDTH);
    localparam int PLANES_PER_FRAME = ROW_PAIRS * LEVELS;
    // worst plane: full shift plus the msb lit time, a few cycles of latch and hold
    localparam int PLANE_MAX_CYCLES = 2 * PIXEL_WIDTH + (BASE_TIMEOUT << (LEVELS - 1)) + 4;
    localparam int FRAME_CYCLES     = PLANES_PER_FRAME * PLANE_MAX_CYCLES;
    // reset, image load, then about four frames of tests, with margin
    localparam int TIMEOUT_CYCLES   = 10 + PANEL_ROWS * PIXEL_WIDTH + 6 * FRAME_CYCLES;

    logic                      clk_in;
    logic                      reset;
    logic                      wr_en;
    logic [ROW_BITS-1:0]       wr_row;
    logic [COL_BITS-1:0]       wr_col;
    logic [LEVELS-1:0]         wr_red;
    logic [LEVELS-1:0]         wr_green;
    logic [LEVELS-1:0]         wr_blue;
    logic [2:0]                rgb_top;
    logic [2:0]                rgb_bottom;
    logic [$clog2(ROW_PAIRS)-1:0] row_address;
    logic                      clk_pixel;
    logic                      row_latch;
    logic                      output_enable;

    // reference image, channels indexed by color_e
    logic [LEVELS-1:0] image [PANEL_ROWS][PIXEL_WIDTH][3];
    int seed = 32'h70f9d137;
    int error_count = 0;

    // monitor state, planes are numbered from reset in scan order
    int   shift_plane    = 0;
    int   latched_plane  = 0;
    int   pulse_count    = 0;
    int   oe_run         = 0;
    int   latches_seen   = 0;
    int   frames_started = 0;
    int   pulses_checked = 0;
    int   rewrite_hits   = 0;
    int   watch_row      = -1;
    int   watch_col      = -1;
    logic prev_latch     = 1'b0;
    logic prev_oe        = 1'b0;
    logic check_pixels   = 1'b0;

    led_matrix_top dut_i (
        .clk_in       (clk_in),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_row       (wr_row),
        .wr_col       (wr_col),
        .wr_red       (wr_red),
        .wr_green     (wr_green),
        .wr_blue      (wr_blue),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom),
        .row_address  (row_address),
        .clk_pixel    (clk_pixel),
        .row_latch    (row_latch),
        .output_enable(output_enable)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // planes go msb to lsb within a row pair, row pairs wrap
    function automatic int row_of(input int plane);
        return (plane / LEVELS) % ROW_PAIRS;
    endfunction

    function automatic int bit_of(input int plane);
        return LEVELS - 1 - (plane % LEVELS);
    endfunction

    // lit time doubles per bit weight
    function automatic int lit_cycles(input int plane);
        return BASE_TIMEOUT << bit_of(plane);
    endfunction

    task automatic report_mismatch(input string name, input int got, input int expected);
        error_count++;
        $display("Error: %s got 0x%0h expected 0x%0h", name, got, expected);
        $display("Finished with errors");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "stopped at the first failure");
    endtask

    // one pixel clock, column counts down from the last one
    task automatic check_pulse();
        int         row;
        int         col;
        int         bit_index;
        logic [2:0] exp_top;
        logic [2:0] exp_bottom;
        assert (pulse_count < PIXEL_WIDTH)
            else report_failure("more clk_pixel pulses than columns before row_latch");
        assert (!row_latch) else report_failure("clk_pixel and row_latch high together");
        // early start, previous plane must be close to dark
        if (pulse_count == 0 && output_enable && latches_seen > 0) begin
            assert (oe_run >= lit_cycles(latched_plane) - OVERLAP)
                else report_mismatch("output_enable run at first clk_pixel", oe_run,
                                     lit_cycles(latched_plane) - OVERLAP);
        end
        row       = row_of(shift_plane);
        col       = PIXEL_WIDTH - 1 - pulse_count;
        bit_index = bit_of(shift_plane);
        if (check_pixels) begin
            for (int ch = 0; ch < 3; ch++) begin
                exp_top[ch]    = image[row][col][ch][bit_index];
                exp_bottom[ch] = image[row + ROW_PAIRS][col][ch][bit_index];
            end
            assert (rgb_top == exp_top)
                else report_mismatch("rgb_top", int'(rgb_top), int'(exp_top));
            assert (rgb_bottom == exp_bottom)
                else report_mismatch("rgb_bottom", int'(rgb_bottom), int'(exp_bottom));
            pulses_checked++;
            if ((row == watch_row || row + ROW_PAIRS == watch_row) && col == watch_col) begin
                rewrite_hits++;
            end
        end
        pulse_count++;
    endtask

    // end of a plane shift
    task automatic check_latch();
        assert (!output_enable) else report_failure("row_latch high while output_enable high");
        assert (!prev_latch) else report_failure("row_latch longer than one cycle");
        assert (pulse_count == PIXEL_WIDTH)
            else report_mismatch("clk_pixel pulses per plane", pulse_count, PIXEL_WIDTH);
        latched_plane = shift_plane;
        shift_plane++;
        pulse_count = 0;
        latches_seen++;
        // next shift is row pair 0, msb
        if (latched_plane % PLANES_PER_FRAME == PLANES_PER_FRAME - 1) begin
            frames_started++;
        end
    endtask

    // panel side monitor, samples the cycle that ends at each edge
    always @(posedge clk_in) begin
        if (!reset) begin
            // lit run of the plane latched last, checked before a new latch moves it on
            if (output_enable) begin
                oe_run++;
                assert (latches_seen > 0)
                    else report_failure("output_enable high before the first row_latch");
                assert (int'(row_address) == row_of(latched_plane))
                    else report_mismatch("row_address", int'(row_address),
                                         row_of(latched_plane));
            end else if (prev_oe) begin
                assert (oe_run == lit_cycles(latched_plane))
                    else report_mismatch("output_enable run length", oe_run,
                                         lit_cycles(latched_plane));
                oe_run = 0;
            end
            if (prev_latch) begin
                assert (output_enable)
                    else report_failure("output_enable did not rise after row_latch");
            end
            if (clk_pixel) begin
                check_pulse();
            end
            if (row_latch) begin
                check_latch();
            end
            prev_latch = row_latch;
            prev_oe    = output_enable;
        end
    end

    // leaves wr_en high, the caller drops it
    task automatic write_pixel(input int row, input int col, input logic [LEVELS-1:0] red,
                               input logic [LEVELS-1:0] green, input logic [LEVELS-1:0] blue);
        @(posedge clk_in);
        wr_en    <= 1'b1;
        wr_row   <= ROW_BITS'(row);
        wr_col   <= COL_BITS'(col);
        wr_red   <= red;
        wr_green <= green;
        wr_blue  <= blue;
    endtask

    // random image, starts under reset and runs on past it
    task automatic load_image();
        logic [LEVELS-1:0] red;
        logic [LEVELS-1:0] green;
        logic [LEVELS-1:0] blue;
        for (int r = 0; r < PANEL_ROWS; r++) begin
            for (int c = 0; c < PIXEL_WIDTH; c++) begin
                red   = LEVELS'($random(seed));
                green = LEVELS'($random(seed));
                blue  = LEVELS'($random(seed));
                image[r][c][RED]   = red;
                image[r][c][GREEN] = green;
                image[r][c][BLUE]  = blue;
                write_pixel(r, c, red, green, blue);
            end
        end
        @(posedge clk_in);
        wr_en <= 1'b0;
    endtask

    // returns on the falling edge after the latch that ends a frame
    task automatic wait_frame_start();
        int start_count;
        @(negedge clk_in);
        start_count = frames_started;
        while (frames_started == start_count) begin
            @(negedge clk_in);
        end
    endtask

    // quiet outputs through reset and idle, then row pair 0 msb lights first
    task automatic reset_state_test();
        int run_cycles;
        repeat (9) @(posedge clk_in);
        @(negedge clk_in);
        assert (!output_enable && !row_latch && !clk_pixel)
            else report_failure("panel strobes active during reset");
        assert (row_address == '0) else report_mismatch("row_address", int'(row_address), 0);
        @(posedge clk_in);
        reset <= 1'b0;
        @(negedge clk_in);
        assert (!output_enable && !row_latch && !clk_pixel)
            else report_failure("panel strobes active in the idle cycle after reset");
        assert (row_address == '0) else report_mismatch("row_address", int'(row_address), 0);
        while (latches_seen == 0) begin
            @(negedge clk_in);
        end
        run_cycles = 0;
        while (output_enable) begin
            assert (row_address == '0)
                else report_mismatch("row_address", int'(row_address), 0);
            run_cycles++;
            @(negedge clk_in);
        end
        assert (run_cycles == (BASE_TIMEOUT << (LEVELS - 1)))
            else report_mismatch("first output_enable run", run_cycles,
                                 BASE_TIMEOUT << (LEVELS - 1));
    endtask

    // one whole frame with every pixel bit compared
    task automatic frame_scan_test();
        int pulses_before;
        int latches_before;
        wait_frame_start();
        check_pixels   = 1'b1;
        pulses_before  = pulses_checked;
        latches_before = latches_seen;
        wait_frame_start();
        assert (pulses_checked - pulses_before == PIXEL_WIDTH * PLANES_PER_FRAME)
            else report_mismatch("clk_pixel pulses per frame", pulses_checked - pulses_before,
                                 PIXEL_WIDTH * PLANES_PER_FRAME);
        assert (latches_seen - latches_before == PLANES_PER_FRAME)
            else report_mismatch("row_latch pulses per frame", latches_seen - latches_before,
                                 PLANES_PER_FRAME);
    endtask

    // invert a bottom half pixel mid scan, every bit plane must show the new value
    task automatic rewrite_test();
        logic [LEVELS-1:0] red;
        logic [LEVELS-1:0] green;
        logic [LEVELS-1:0] blue;
        check_pixels = 1'b0;
        watch_row    = ROW_PAIRS + 1;
        watch_col    = 3;
        red   = ~image[watch_row][watch_col][RED];
        green = ~image[watch_row][watch_col][GREEN];
        blue  = ~image[watch_row][watch_col][BLUE];
        image[watch_row][watch_col][RED]   = red;
        image[watch_row][watch_col][GREEN] = green;
        image[watch_row][watch_col][BLUE]  = blue;
        write_pixel(watch_row, watch_col, red, green, blue);
        @(posedge clk_in);
        wr_en <= 1'b0;
        wait_frame_start();
        rewrite_hits = 0;
        check_pixels = 1'b1;
        wait_frame_start();
        assert (rewrite_hits == LEVELS)
            else report_mismatch("pulses of the rewritten pixel", rewrite_hits, LEVELS);
    endtask

    initial begin
        reset    = 1'b1;
        wr_en    = 1'b0;
        wr_row   = '0;
        wr_col   = '0;
        wr_red   = '0;
        wr_green = '0;
        wr_blue  = '0;
        fork
            load_image();
            reset_state_test();
        join
        frame_scan_test();
        rewrite_test();
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_in);
        $display("watchdog expired after %0d cycles, the scan stopped making progress",
                 TIMEOUT_CYCLES);
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

endmodule

/* sources.f */
panel_cfg_pkg.sv
scan_pkg.sv
scan_if.sv
scan_timer.sv
brightness_timeout.sv
matrix_scan.sv
frame_buffer.sv
led_matrix_top.sv
tb_led_matrix.sv

/* Makefile */
# Verilator build and run of the LED matrix testbench
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_led_matrix
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log, not the exit status
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
